// ==== sim.f ====
design/align_pkg.sv
design/seq_store.sv
design/dir_mem.sv
design/score_fill.sv
design/step_counter.sv
design/align_ctrl.sv
design/trace_emit.sv
design/aligner_top.sv
tb/aligner_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the aligner testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module aligner_tb -f sim.f -o aligner_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/aligner_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '** PASS **' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tb/aligner_tb.sv ====
`timescale 1ns/1ns

module aligner_tb;

    localparam int N              = align_pkg::SEQ_LEN;
    localparam int NUM_ROWS       = 6;
    localparam int CLK_PERIOD     = 20;
    localparam int ROW_LIMIT      = N * N + 2 * N + 30;     // Cycles allowed per alignment
    localparam int TIMEOUT_CYCLES = NUM_ROWS * ROW_LIMIT;

    logic              clk = 1'b0;
    logic              rst;
    logic              load_a, load_b, start;
    align_pkg::idx_t   load_idx;
    align_pkg::sym_t   load_sym;
    logic              busy, pair_valid, done;
    align_pkg::sym_t   pair_a, pair_b;
    align_pkg::score_t score;

    // Stimulus table with score -1 where only the model knows it
    string             row_name [NUM_ROWS];
    align_pkg::sym_t   tbl_a [NUM_ROWS][N];
    align_pkg::sym_t   tbl_b [NUM_ROWS][N];
    int                tbl_score [NUM_ROWS];

    align_pkg::sym_t   exp_a[$], exp_b[$];
    align_pkg::score_t exp_run[$];
    align_pkg::score_t exp_corner;

    // Captured by the monitor
    align_pkg::sym_t   got_a[$], got_b[$];
    align_pkg::score_t got_run[$];
    int                got_cyc[$];
    int                cyc = 0;
    int                start_cyc, done_cyc;
    logic              start_seen, done_seen, busy_at_done, busy_at_last;
    align_pkg::score_t score_at_done;
    int                mismatch_errs = 0;
    int                other_errs = 0;

    aligner_top uut (
        .clk        (clk),
        .rst        (rst),
        .load_a     (load_a),
        .load_b     (load_b),
        .load_idx   (load_idx),
        .load_sym   (load_sym),
        .start      (start),
        .busy       (busy),
        .pair_valid (pair_valid),
        .pair_a     (pair_a),
        .pair_b     (pair_b),
        .score      (score),
        .done       (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Outputs sampled mid-cycle away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            if (start && !busy && !start_seen) begin
                start_seen = 1'b1;
                start_cyc  = cyc;
            end
            if (pair_valid) begin
                got_a.push_back(pair_a);
                got_b.push_back(pair_b);
                got_run.push_back(score);
                got_cyc.push_back(cyc);
                busy_at_last = busy;
            end
            if (done) begin
                done_seen     = 1'b1;
                done_cyc      = cyc;
                busy_at_done  = busy;
                score_at_done = score;
            end
        end
    end

    function automatic align_pkg::sym_t sym_of(input byte c);
        case (c)
            "C":     return align_pkg::SYM_C;
            "G":     return align_pkg::SYM_G;
            "T":     return align_pkg::SYM_T;
            default: return align_pkg::SYM_A;
        endcase
    endfunction

    task automatic set_row(input int r, input string nm, input string a, input string b,
                           input int sc);
        int i;
        row_name[r]  = nm;
        tbl_score[r] = sc;
        for (i = 0; i < N; i++) begin
            tbl_a[r][i] = sym_of(a[i]);
            tbl_b[r][i] = sym_of(b[i]);
        end
    endtask

    task automatic build_table();
        int r, i;
        set_row(0, "identical", "ACGTACGT", "ACGTACGT", N);
        set_row(1, "all_diff",  "AAAAAAAA", "CCCCCCCC", -N);
        set_row(2, "shift_one", "ACGTACGT", "CGTACGTA", 3);    // 7 matches and 2 gaps
        set_row(3, "reversed",  "ACGTACGT", "TGCATGCA", -5);   // 3 matches, 4 mismatches and 2 gaps
        for (r = 4; r < NUM_ROWS; r++) begin
            row_name[r]  = $sformatf("random_%0d", r - 4);
            tbl_score[r] = -1;
            for (i = 0; i < N; i++) begin
                tbl_a[r][i] = align_pkg::sym_t'($urandom % 4);
                tbl_b[r][i] = align_pkg::sym_t'($urandom % 4);
            end
        end
    endtask

    // Full score matrix and then a walk back from the corner
    task automatic model_align(input int r);
        int h [0:N][0:N];
        int dir [0:N][0:N];     // 0 diagonal, 1 up, 2 left
        int i, j, d, u, l, step, run;
        for (i = 0; i <= N; i++) h[i][0] = -2 * i;
        for (j = 0; j <= N; j++) h[0][j] = -2 * j;
        for (i = 1; i <= N; i++) begin
            for (j = 1; j <= N; j++) begin
                d = h[i-1][j-1] + ((tbl_a[r][i-1] == tbl_b[r][j-1]) ? 1 : -1);
                u = h[i-1][j] - 2;
                l = h[i][j-1] - 2;
                if (d >= u && d >= l) begin
                    h[i][j]   = d;
                    dir[i][j] = 0;
                end else if (u >= l) begin
                    h[i][j]   = u;
                    dir[i][j] = 1;
                end else begin
                    h[i][j]   = l;
                    dir[i][j] = 2;
                end
            end
        end
        exp_a.delete();
        exp_b.delete();
        exp_run.delete();
        exp_corner = align_pkg::score_t'(h[N][N]);
        i   = N;
        j   = N;
        run = 0;
        while (i > 0 || j > 0) begin
            step = (i == 0) ? 2 : (j == 0) ? 1 : dir[i][j];
            if (step == 0) begin
                exp_a.push_back(tbl_a[r][i-1]);
                exp_b.push_back(tbl_b[r][j-1]);
                run += (tbl_a[r][i-1] == tbl_b[r][j-1]) ? 1 : -1;
                i--;
                j--;
            end else if (step == 1) begin
                exp_a.push_back(tbl_a[r][i-1]);
                exp_b.push_back(align_pkg::SYM_DASH);
                run -= 2;
                i--;
            end else begin
                exp_a.push_back(align_pkg::SYM_DASH);
                exp_b.push_back(tbl_b[r][j-1]);
                run -= 2;
                j--;
            end
            exp_run.push_back(align_pkg::score_t'(run));
        end
    endtask

    task automatic check_sym(input string nm, input align_pkg::sym_t exp,
                             input align_pkg::sym_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", nm, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_score(input string nm, input align_pkg::score_t exp,
                               input align_pkg::score_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", nm, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_bit(input string nm, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", nm, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_count(input string nm, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %s: expected %0d, actual %0d", nm, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_reset_state();
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset pair_valid", 1'b0, pair_valid);
        check_bit("reset done", 1'b0, done);
        check_score("reset score", '0, score);
        check_sym("reset pair_a", align_pkg::SYM_NONE, pair_a);
        check_sym("reset pair_b", align_pkg::SYM_NONE, pair_b);
    endtask

    task automatic load_row(input int r);
        int i;
        for (i = 0; i < 2 * N; i++) begin
            @(posedge clk);
            load_a   <= (i < N);
            load_b   <= (i >= N);
            load_idx <= align_pkg::idx_t'(i % N);
            load_sym <= (i < N) ? tbl_a[r][i % N] : tbl_b[r][i % N];
        end
    endtask

    task automatic compare_row(input int r);
        int k, n;
        string nm;
        nm = row_name[r];
        n  = (got_a.size() < exp_a.size()) ? got_a.size() : exp_a.size();
        if (got_a.size() > exp_a.size()) begin
            $display("test %s: too many pairs, %0d emitted but the traceback has %0d",
                     nm, got_a.size(), exp_a.size());
            other_errs++;
        end else if (got_a.size() < exp_a.size()) begin
            $display("test %s: too few pairs, %0d emitted but the traceback has %0d",
                     nm, got_a.size(), exp_a.size());
            other_errs++;
        end
        for (k = 0; k < n; k++) begin
            check_sym($sformatf("%s pair %0d a", nm, k), exp_a[k], got_a[k]);
            check_sym($sformatf("%s pair %0d b", nm, k), exp_b[k], got_b[k]);
            check_score($sformatf("%s pair %0d score", nm, k), exp_run[k], got_run[k]);
        end
        if (got_a.size() > 0) begin
            check_count({nm, " first pair latency"}, N * N + 2, got_cyc[0] - start_cyc);
            check_count({nm, " done after last pair"}, got_cyc[$] + 1, done_cyc);
            check_bit({nm, " busy at last pair"}, 1'b1, busy_at_last);
        end
        check_bit({nm, " busy at done"}, 1'b0, busy_at_done);
        check_score({nm, " final score"}, exp_corner, score_at_done);
        if (tbl_score[r] != -1) begin
            check_score({nm, " table score"}, align_pkg::score_t'(tbl_score[r]), score_at_done);
        end
    endtask

    task automatic run_row(input int r);
        int k;
        logic poke;
        poke = (r % 2 == 1);       // Odd rows get loads and a start while busy
        got_a.delete();
        got_b.delete();
        got_run.delete();
        got_cyc.delete();
        start_seen = 1'b0;
        done_seen  = 1'b0;
        load_row(r);
        @(posedge clk);
        load_b <= 1'b0;
        start  <= 1'b1;
        k = 0;
        while (!done_seen && k < ROW_LIMIT) begin
            @(posedge clk);
            k++;
            start  <= poke && (k == 20);
            load_a <= poke && (k == 10);
            if (k == 10) begin
                load_idx <= '0;
                load_sym <= (tbl_a[r][0] + 3'd1) & 3'd3;   // Differs from the stored symbol
            end
        end
        if (!done_seen) begin
            $display("test %s: no done pulse within %0d cycles of start", row_name[r], ROW_LIMIT);
            other_errs++;
        end else begin
            compare_row(r);
        end
    endtask

    task automatic close_run();
        $display("error counts: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
    endtask

    initial begin
        int r;
        rst      = 1'b1;
        load_a   = 1'b0;
        load_b   = 1'b0;
        load_idx = '0;
        load_sym = align_pkg::SYM_NONE;
        start    = 1'b0;
        void'($urandom(32'h0f53102b));
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset_state();
        for (r = 0; r < NUM_ROWS; r++) begin
            model_align(r);
            run_row(r);
        end
        close_run();
        $finish;
    end

    // Watchdog sized from the per-row budget
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        other_errs++;
        close_run();
        $finish;
    end

endmodule

// ==== design/aligner_top.sv ====
`timescale 1ns/1ns

module aligner_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_a,
    input  logic              load_b,
    input  align_pkg::idx_t   load_idx,
    input  align_pkg::sym_t   load_sym,
    input  logic              start,
    output logic              busy,
    output logic              pair_valid,
    output align_pkg::sym_t   pair_a,
    output align_pkg::sym_t   pair_b,
    output align_pkg::score_t score,
    output logic              done
);

    align_pkg::ctrl_state_t state;
    align_pkg::idx_t        row_idx;
    align_pkg::idx_t        col_idx;
    align_pkg::sym_t        sym_a;
    align_pkg::sym_t        sym_b;
    align_pkg::arrow_t      fill_arrow;     // Arrow produced by the fill datapath
    align_pkg::arrow_t      trace_arrow;    // Arrow read back for traceback
    logic                   arrow_wr;
    logic                   fill_en;
    logic                   trace_en;
    logic                   cnt_clear;
    logic                   fill_last;
    logic                   at_origin;

    align_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .fill_last (fill_last),
        .at_origin (at_origin),
        .state     (state),
        .fill_en   (fill_en),
        .trace_en  (trace_en),
        .cnt_clear (cnt_clear),
        .busy      (busy),
        .done      (done)
    );

    step_counter u_cnt (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .cnt_clear (cnt_clear),
        .arrow     (trace_arrow),
        .row_idx   (row_idx),
        .col_idx   (col_idx),
        .fill_last (fill_last),
        .at_origin (at_origin)
    );

    seq_store u_seq (
        .clk (clk), .rst (rst),
        .load_a (load_a), .load_b (load_b), .load_idx (load_idx), .load_sym (load_sym),
        .wr_lock (busy),
        .row_idx (row_idx), .col_idx (col_idx), .sym_a (sym_a), .sym_b (sym_b)
    );

    score_fill u_fill (
        .clk (clk), .rst (rst), .fill_en (fill_en), .fill_first (cnt_clear),
        .row_idx (row_idx), .col_idx (col_idx), .sym_a (sym_a), .sym_b (sym_b),
        .arrow (fill_arrow), .arrow_wr (arrow_wr)
    );

    dir_mem u_dir (
        .clk (clk), .rst (rst), .wr_en (arrow_wr),
        .wr_row (row_idx), .wr_col (col_idx), .wr_arrow (fill_arrow),
        .rd_row (row_idx), .rd_col (col_idx), .rd_arrow (trace_arrow)
    );

    trace_emit u_emit (
        .clk (clk), .rst (rst), .trace_en (trace_en), .trace_first (cnt_clear),
        .arrow (trace_arrow), .sym_a (sym_a), .sym_b (sym_b),
        .pair_valid (pair_valid), .pair_a (pair_a), .pair_b (pair_b), .score (score)
    );

endmodule

// ==== design/trace_emit.sv ====
`timescale 1ns/1ns

module trace_emit (
    input  logic              clk,
    input  logic              rst,
    input  logic              trace_en,
    input  logic              trace_first,
    input  align_pkg::arrow_t arrow,
    input  align_pkg::sym_t   sym_a,
    input  align_pkg::sym_t   sym_b,
    output logic              pair_valid,
    output align_pkg::sym_t   pair_a,
    output align_pkg::sym_t   pair_b,
    output align_pkg::score_t score
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pair_valid <= 1'b0;
            pair_a     <= align_pkg::SYM_NONE;
            pair_b     <= align_pkg::SYM_NONE;
            score      <= '0;
        end else begin
            pair_valid <= 1'b0;
            pair_a     <= align_pkg::SYM_NONE;
            pair_b     <= align_pkg::SYM_NONE;
            if (trace_first) begin
                score <= '0;
            end else if (trace_en) begin
                // Score taken from the live symbols, same edge as the pair
                case (arrow)
                    align_pkg::ARROW_DIAG: begin
                        pair_valid <= 1'b1;
                        pair_a     <= sym_a;
                        pair_b     <= sym_b;
                        score      <= score + ((sym_a == sym_b) ? align_pkg::MATCH_SCORE
                                                                : align_pkg::MISMATCH_SCORE);
                    end
                    align_pkg::ARROW_UP: begin
                        pair_valid <= 1'b1;
                        pair_a     <= sym_a;
                        pair_b     <= align_pkg::SYM_DASH;  // Gap in B
                        score      <= score + align_pkg::GAP_SCORE;
                    end
                    align_pkg::ARROW_LEFT: begin
                        pair_valid <= 1'b1;
                        pair_a     <= align_pkg::SYM_DASH;  // Gap in A
                        pair_b     <= sym_b;
                        score      <= score + align_pkg::GAP_SCORE;
                    end
                    default: ;              // Unwritten cell, nothing emitted
                endcase
            end
        end
    end

endmodule

// ==== design/align_ctrl.sv ====
`timescale 1ns/1ns

module align_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   fill_last,
    input  logic                   at_origin,
    output align_pkg::ctrl_state_t state,
    output logic                   fill_en,
    output logic                   trace_en,
    output logic                   cnt_clear,
    output logic                   busy,
    output logic                   done
);

    align_pkg::ctrl_state_t state_nxt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= align_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            align_pkg::IDLE: begin
                if (start) state_nxt = align_pkg::FILL;
            end
            align_pkg::FILL: begin
                if (fill_last) state_nxt = align_pkg::TRACE;
            end
            align_pkg::TRACE: begin
                // Origin reached, the last pair is already registered
                if (at_origin) state_nxt = align_pkg::DONE;
            end
            align_pkg::DONE: begin
                state_nxt = align_pkg::IDLE;    // Single-cycle completion
            end
            default: begin
                state_nxt = align_pkg::IDLE;
            end
        endcase
    end

    // Start clears counters and scores in the same edge it is taken
    assign cnt_clear = (state == align_pkg::IDLE) && start;

    assign fill_en  = (state == align_pkg::FILL);
    assign trace_en = (state == align_pkg::TRACE) && !at_origin;

    // Low again in DONE, so busy drops as done rises
    assign busy = (state == align_pkg::FILL) || (state == align_pkg::TRACE);
    assign done = (state == align_pkg::DONE);

endmodule

// ==== design/step_counter.sv ====
`timescale 1ns/1ns

module step_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  align_pkg::ctrl_state_t state,
    input  logic                   cnt_clear,
    input  align_pkg::arrow_t      arrow,
    output align_pkg::idx_t        row_idx,
    output align_pkg::idx_t        col_idx,
    output logic                   fill_last,
    output logic                   at_origin
);

    localparam align_pkg::idx_t LAST = align_pkg::idx_t'(align_pkg::SEQ_LEN);
    localparam align_pkg::idx_t ONE  = align_pkg::idx_t'(1);

    logic row_end;
    logic step_row;
    logic step_col;

    assign row_end   = (col_idx == LAST);
    assign fill_last = (state == align_pkg::FILL) && row_end && (row_idx == LAST);
    assign at_origin = (row_idx == '0) && (col_idx == '0);

    // Arrow decides which index walks back
    assign step_row = (arrow == align_pkg::ARROW_DIAG) || (arrow == align_pkg::ARROW_UP);
    assign step_col = (arrow == align_pkg::ARROW_DIAG) || (arrow == align_pkg::ARROW_LEFT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_idx <= '0;
            col_idx <= '0;
        end else if (cnt_clear) begin
            row_idx <= ONE;                 // First interior cell
            col_idx <= ONE;
        end else if (state == align_pkg::FILL) begin
            if (fill_last) begin
                row_idx <= LAST;            // Traceback starts at the corner
                col_idx <= LAST;
            end else if (row_end) begin
                row_idx <= row_idx + ONE;
                col_idx <= ONE;
            end else begin
                col_idx <= col_idx + ONE;
            end
        end else if (state == align_pkg::TRACE && !at_origin) begin
            if (step_row) row_idx <= row_idx - ONE;
            if (step_col) col_idx <= col_idx - ONE;
        end
    end

endmodule

// ==== design/score_fill.sv ====
`timescale 1ns/1ns

module score_fill (
    input  logic              clk,
    input  logic              rst,
    input  logic              fill_en,
    input  logic              fill_first,
    input  align_pkg::idx_t   row_idx,
    input  align_pkg::idx_t   col_idx,
    input  align_pkg::sym_t   sym_a,
    input  align_pkg::sym_t   sym_b,
    output align_pkg::arrow_t arrow,
    output logic              arrow_wr
);

    // Scores of the previous row, replaced cell by cell as the current row advances.
    // Entry 0 tracks the column-0 boundary of the row being filled.
    align_pkg::score_t row_buf [0:align_pkg::SEQ_LEN];
    align_pkg::score_t left_q;      // Current row, column c-1
    align_pkg::score_t diag_q;      // Previous row, column c-1

    align_pkg::score_t up_sc;
    align_pkg::score_t left_sc;
    align_pkg::score_t diag_sc;
    align_pkg::score_t sub_sc;
    align_pkg::score_t from_diag;
    align_pkg::score_t from_up;
    align_pkg::score_t from_left;
    align_pkg::score_t best;
    logic              first_col;

    assign first_col = (col_idx == align_pkg::idx_t'(1));

    // Column 1 takes its neighbours from the boundary entry
    assign up_sc   = row_buf[col_idx];
    assign diag_sc = first_col ? row_buf[0] : diag_q;
    assign left_sc = first_col ? row_buf[0] + align_pkg::GAP_SCORE : left_q;

    assign sub_sc    = (sym_a == sym_b) ? align_pkg::MATCH_SCORE : align_pkg::MISMATCH_SCORE;
    assign from_diag = diag_sc + sub_sc;
    assign from_up   = up_sc + align_pkg::GAP_SCORE;
    assign from_left = left_sc + align_pkg::GAP_SCORE;

    // Ties resolve diagonal first, then up
    always_comb begin
        if (from_diag >= from_up && from_diag >= from_left) begin
            arrow = align_pkg::ARROW_DIAG;
            best  = from_diag;
        end else if (from_up >= from_left) begin
            arrow = align_pkg::ARROW_UP;
            best  = from_up;
        end else begin
            arrow = align_pkg::ARROW_LEFT;
            best  = from_left;
        end
    end

    assign arrow_wr = fill_en;      // One cell per fill cycle

    always_ff @(posedge clk) begin
        if (fill_first) begin
            // Row 0 boundary, gap cost times column
            for (int j = 0; j <= align_pkg::SEQ_LEN; j++) begin
                row_buf[j] <= align_pkg::score_t'(int'(align_pkg::GAP_SCORE) * j);
            end
        end else if (fill_en) begin
            if (first_col) begin
                row_buf[0] <= left_sc;  // Advance boundary to this row
            end
            row_buf[col_idx] <= best;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_q <= '0;
            diag_q <= '0;
        end else if (fill_en) begin
            left_q <= best;
            diag_q <= up_sc;        // Cell above becomes next diagonal
        end
    end

endmodule

// ==== design/dir_mem.sv ====
`timescale 1ns/1ns

module dir_mem (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  align_pkg::idx_t   wr_row,
    input  align_pkg::idx_t   wr_col,
    input  align_pkg::arrow_t wr_arrow,
    input  align_pkg::idx_t   rd_row,
    input  align_pkg::idx_t   rd_col,
    output align_pkg::arrow_t rd_arrow
);

    // Interior cells only, row and column 1..SEQ_LEN stored at 0..SEQ_LEN-1
    align_pkg::arrow_t mem [0:align_pkg::SEQ_LEN-1][0:align_pkg::SEQ_LEN-1];
    align_pkg::idx_t   wr_r, wr_c, rd_r, rd_c;

    assign wr_r = wr_row - align_pkg::idx_t'(1);
    assign wr_c = wr_col - align_pkg::idx_t'(1);
    assign rd_r = rd_row - align_pkg::idx_t'(1);
    assign rd_c = rd_col - align_pkg::idx_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '{default: '{default: '0}};
        end else if (wr_en) begin
            mem[wr_r[align_pkg::POS_W-1:0]][wr_c[align_pkg::POS_W-1:0]] <= wr_arrow;
        end
    end

    // Top edge always walks left, left edge always walks up
    assign rd_arrow = (rd_row == '0) ? align_pkg::ARROW_LEFT :
                      (rd_col == '0) ? align_pkg::ARROW_UP   :
                      mem[rd_r[align_pkg::POS_W-1:0]][rd_c[align_pkg::POS_W-1:0]];

endmodule

// ==== design/seq_store.sv ====
`timescale 1ns/1ns

module seq_store (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_a,
    input  logic            load_b,
    input  align_pkg::idx_t load_idx,
    input  align_pkg::sym_t load_sym,
    input  logic            wr_lock,
    input  align_pkg::idx_t row_idx,
    input  align_pkg::idx_t col_idx,
    output align_pkg::sym_t sym_a,
    output align_pkg::sym_t sym_b
);

    align_pkg::sym_t seq_a [0:align_pkg::SEQ_LEN-1];
    align_pkg::sym_t seq_b [0:align_pkg::SEQ_LEN-1];
    align_pkg::idx_t a_pos;
    align_pkg::idx_t b_pos;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < align_pkg::SEQ_LEN; i++) begin
                seq_a[i] <= align_pkg::SYM_NONE;
                seq_b[i] <= align_pkg::SYM_NONE;
            end
        end else if (!wr_lock) begin   // Frozen while an alignment runs
            if (load_a) seq_a[load_idx[align_pkg::POS_W-1:0]] <= load_sym;
            if (load_b) seq_b[load_idx[align_pkg::POS_W-1:0]] <= load_sym;
        end
    end

    // Matrix row i pairs with symbol i-1
    assign a_pos = row_idx - align_pkg::idx_t'(1);
    assign b_pos = col_idx - align_pkg::idx_t'(1);
    assign sym_a = (row_idx == '0) ? align_pkg::SYM_NONE : seq_a[a_pos[align_pkg::POS_W-1:0]];
    assign sym_b = (col_idx == '0) ? align_pkg::SYM_NONE : seq_b[b_pos[align_pkg::POS_W-1:0]];

endmodule

// ==== design/align_pkg.sv ====
package align_pkg;

    // Problem size
    localparam int SEQ_LEN = 8;
    localparam int IDX_W   = $clog2(SEQ_LEN + 1);   // Matrix index 0..SEQ_LEN
    localparam int POS_W   = $clog2(SEQ_LEN);       // Storage address 0..SEQ_LEN-1
    localparam int SYM_W   = 3;
    localparam int SCORE_W = 7;                     // Holds -32 .. +8 with margin

    typedef logic [SYM_W-1:0]          sym_t;
    typedef logic [2:0]                arrow_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [IDX_W-1:0]          idx_t;

    // Nucleotide codes
    localparam sym_t SYM_A    = 3'd0;
    localparam sym_t SYM_C    = 3'd1;
    localparam sym_t SYM_G    = 3'd2;
    localparam sym_t SYM_T    = 3'd3;
    localparam sym_t SYM_DASH = 3'd7;   // Gap in the aligned output
    localparam sym_t SYM_NONE = 3'd0;   // Idle value on the pair outputs

    // One-hot traceback directions
    localparam arrow_t ARROW_DIAG = 3'b001;   // Consumes A and B
    localparam arrow_t ARROW_UP   = 3'b010;   // Consumes A, dash on B
    localparam arrow_t ARROW_LEFT = 3'b100;   // Consumes B, dash on A

    // Linear gap scoring
    localparam score_t MATCH_SCORE    = score_t'(1);
    localparam score_t MISMATCH_SCORE = score_t'(-1);
    localparam score_t GAP_SCORE      = score_t'(-2);

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        TRACE,
        DONE
    } ctrl_state_t;

endpackage
